/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dtm_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+src
src/dtm_pkg.sv
src/dtm_tap.sv
src/dtm_dr_shift.sv
src/dtm_dmi_port.sv
src/dtm_top.sv
sim/tb_clk_gen.sv
sim/dtm_tb.sv

/* sim/dtm_tb.sv */
/*
 * Testbench for the JTAG DTM
 * JTAG scan tasks, debug-module model, checking assertions
 * Cycle timeout and final report
 */

`timescale 1ns/1ns

`include "dtm_cfg.svh"

module dtm_tb;

  localparam int unsigned MaxCycles = 4000;
  localparam logic [31:0] LcgSeed   = 32'h62d062e1;

  logic tck, trst_n, tms_i, td_i, td_o, tdo_oe_o;
  logic                  dmi_req_valid_o, dmi_rst_no;
  logic [`DTM_ABITS-1:0] dmi_req_addr_o;
  dtm_pkg::dmi_op_e      dmi_req_op_o;
  logic [31:0]           dmi_req_data_o;
  logic                  dmi_resp_valid_i, dmi_resp_err_i;
  logic [31:0]           dmi_resp_data_i;

  tb_clk_gen clk_gen_i (.tck_o(tck), .trst_no(trst_n));

  dtm_top dtm_top_i (
    .tck_i(tck), .trst_ni(trst_n), .tms_i(tms_i), .td_i(td_i),
    .td_o(td_o), .tdo_oe_o(tdo_oe_o),
    .dmi_req_valid_o(dmi_req_valid_o), .dmi_req_addr_o(dmi_req_addr_o),
    .dmi_req_op_o(dmi_req_op_o), .dmi_req_data_o(dmi_req_data_o),
    .dmi_rst_no(dmi_rst_no), .dmi_resp_valid_i(dmi_resp_valid_i),
    .dmi_resp_data_i(dmi_resp_data_i), .dmi_resp_err_i(dmi_resp_err_i)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // --------------------
  // Debug module model
  // --------------------
  logic [31:0]      mem [0:127];
  logic [31:0]      lcg_q;
  logic             dm_busy, hold_resp;
  int unsigned      delay_cnt, req_count, rst_count, cycles;
  logic [6:0]       cur_addr;
  dtm_pkg::dmi_op_e cur_op;

  initial begin
    for (int a = 0; a < 128; a++) begin
      mem[a] = {a[6:0], 1'b1, ~a[6:0], 1'b0, a[6:0], 9'h15a};
    end
  end

  always @(posedge tck) begin
    dmi_resp_valid_i <= 1'b0;
    if (dmi_req_valid_o) begin
      dm_busy   <= 1'b1;
      cur_addr  <= dmi_req_addr_o;
      cur_op    <= dmi_req_op_o;
      lcg_q     <= lcg_next(lcg_q);
      delay_cnt <= (lcg_q[23:16] % 8) + 1;
      req_count <= req_count + 1;
      if (dmi_req_op_o == dtm_pkg::DMI_WRITE) begin
        mem[dmi_req_addr_o] <= dmi_req_data_o;
      end
    end else if (dm_busy && !hold_resp) begin
      if (delay_cnt > 1) begin
        delay_cnt <= delay_cnt - 1;
      end else begin
        // Single response strobe
        // Address 0x7f always faults
        dm_busy          <= 1'b0;
        dmi_resp_valid_i <= 1'b1;
        dmi_resp_err_i   <= (cur_addr == 7'h7f);
        dmi_resp_data_i  <= (cur_op == dtm_pkg::DMI_READ) ? mem[cur_addr] : 32'h0;
      end
    end
    if (!dmi_rst_no) begin
      rst_count <= rst_count + 1;
    end
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      stop_on_error($sformatf("Timeout after %0d cycles", cycles));
    end
  end

  // --------------------
  // Request checks
  // --------------------
  logic                  req_allowed;
  logic [`DTM_ABITS-1:0] exp_addr;
  dtm_pkg::dmi_op_e      exp_op;
  logic [31:0]           exp_data;
  logic                  exp_oe;

  a_req_allowed: assert property (@(posedge tck) disable iff (!trst_n)
    dmi_req_valid_o |-> req_allowed)
    else stop_on_error("DMI request issued while a scan should have been refused");

  a_req_fields: assert property (@(posedge tck) disable iff (!trst_n)
    dmi_req_valid_o |-> (dmi_req_addr_o == exp_addr && dmi_req_op_o == exp_op
                         && dmi_req_data_o == exp_data))
    else stop_on_error($sformatf("Mismatch dmi_req addr/op/data: got %h/%h/%h expected %h/%h/%h",
      dmi_req_addr_o, dmi_req_op_o, dmi_req_data_o, exp_addr, exp_op, exp_data));

  // Pad enable is high exactly while bits are being shifted
  a_oe_shift: assert property (@(posedge tck) disable iff (!trst_n)
    tdo_oe_o == exp_oe)
    else stop_on_error($sformatf("Mismatch tdo_oe_o: got %h expected %h",
      $sampled(tdo_oe_o), $sampled(exp_oe)));

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  // --------------------
  // JTAG driver
  // --------------------
  // RTI to Shift, n bits LSB first, back to RTI through Update
  task automatic scan(input bit is_ir, input int n, input logic [63:0] din,
                      output logic [63:0] dout);
    dout = '0;
    @(posedge tck);
    tms_i <= 1'b1;
    if (is_ir) begin
      @(posedge tck);
      tms_i <= 1'b1;
    end
    @(posedge tck);
    tms_i <= 1'b0;
    @(posedge tck);
    tms_i <= 1'b0;
    for (int i = 0; i < n; i++) begin
      @(posedge tck);
      if (i > 0) begin
        dout[i-1] = td_o;
      end
      td_i   <= din[i];
      tms_i  <= (i == n - 1);
      // Enable follows the Shift state half a cycle later
      exp_oe <= 1'b1;
    end
    @(posedge tck);
    dout[n-1] = td_o;
    tms_i  <= 1'b1;
    td_i   <= 1'b0;
    exp_oe <= 1'b0;
    @(posedge tck);
    tms_i <= 1'b0;
    @(posedge tck);
  endtask

  task automatic load_ir(input logic [`DTM_IR_LEN-1:0] code);
    logic [63:0] dout;
    scan(1'b1, `DTM_IR_LEN, 64'(code), dout);
    check_value("ir capture low bits", dout[1:0], 64'h1);
  endtask

  task automatic dmi_scan(input logic [6:0] addr, input logic [31:0] data,
                          input logic [1:0] op, output logic [63:0] dout);
    scan(1'b0, `DTM_ABITS + 34, 64'({addr, data, op}), dout);
  endtask

  task automatic await_response();
    repeat (2) @(posedge tck);
    while (dm_busy) @(posedge tck);
    @(posedge tck);
  endtask

  task automatic enter_tlr();
    repeat (5) begin
      @(posedge tck);
      tms_i <= 1'b1;
    end
    @(posedge tck);
    tms_i <= 1'b0;
    @(posedge tck);
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [63:0] dout;
    int unsigned cnt;
    tms_i = 0;
    td_i = 0;
    dmi_resp_valid_i = 0;
    dmi_resp_data_i = '0;
    dmi_resp_err_i = 0;
    lcg_q = LcgSeed;
    dm_busy = 0;
    hold_resp = 0;
    delay_cnt = 0;
    req_count = 0;
    rst_count = 0;
    cycles = 0;
    req_allowed = 0;
    exp_addr = '0;
    exp_op = dtm_pkg::DMI_NOP;
    exp_data = '0;
    exp_oe = 0;
    cur_addr = '0;
    cur_op = dtm_pkg::DMI_NOP;
    wait (trst_n === 1'b1);
    @(posedge tck);
    // IDCODE after reset, then bypass paths
    scan(1'b0, 32, 64'h0, dout);
    check_value("idcode", dout[31:0], 64'(`DTM_IDCODE));
    load_ir(5'h1f);
    scan(1'b0, 16, 64'hb3c5, dout);
    check_value("bypass1 dr", dout[15:0], 64'h678a);
    load_ir(5'h0a);
    scan(1'b0, 16, 64'h5a0f, dout);
    check_value("undefined ir dr", dout[15:0], 64'hb41e);
    // DTMCS fields
    load_ir(5'h10);
    scan(1'b0, 32, 64'h0, dout);
    check_value("dtmcs", dout[31:0], 64'((1 << 12) | (`DTM_ABITS << 4) | `DTM_VERSION));
    // Write then read back
    load_ir(5'h11);
    req_allowed = 1;
    exp_addr = 7'h05;
    exp_op = dtm_pkg::DMI_WRITE;
    exp_data = 32'hcafe1234;
    cnt = req_count;
    dmi_scan(7'h05, 32'hcafe1234, 2'd2, dout);
    await_response();
    check_value("write request count", 64'(req_count), 64'(cnt + 1));
    exp_op = dtm_pkg::DMI_READ;
    exp_data = 32'h0;
    dmi_scan(7'h05, 32'h0, 2'd1, dout);
    await_response();
    req_allowed = 0;
    dmi_scan(7'h00, 32'h0, 2'd0, dout);
    check_value("dmi read result", dout[40:0], 64'({7'h05, 32'hcafe1234, 2'd0}));
    // Busy while the response is held back
    hold_resp = 1;
    req_allowed = 1;
    exp_addr = 7'h0a;
    exp_op = dtm_pkg::DMI_WRITE;
    exp_data = 32'h11223344;
    dmi_scan(7'h0a, 32'h11223344, 2'd2, dout);
    // Strobe arrives the cycle after Update-DR
    @(posedge tck);
    req_allowed = 0;
    dmi_scan(7'h0b, 32'hdeadbeef, 2'd2, dout);
    check_value("dmi op while pending", dout[1:0], 64'h3);
    hold_resp = 0;
    await_response();
    dmi_scan(7'h0a, 32'h0, 2'd1, dout);
    check_value("dmi op sticky busy", dout[1:0], 64'h3);
    load_ir(5'h10);
    scan(1'b0, 32, 64'h0001_0000, dout);
    check_value("dtmcs dmistat busy", dout[11:10], 64'h3);
    load_ir(5'h11);
    req_allowed = 1;
    exp_op = dtm_pkg::DMI_READ;
    exp_data = 32'h0;
    cnt = req_count;
    dmi_scan(7'h0a, 32'h0, 2'd1, dout);
    check_value("dmi op after dmireset", dout[1:0], 64'h0);
    await_response();
    check_value("read request count", 64'(req_count), 64'(cnt + 1));
    req_allowed = 0;
    dmi_scan(7'h00, 32'h0, 2'd0, dout);
    check_value("dmi read after busy", dout[33:0], 64'({32'h11223344, 2'd0}));
    // Error response and debug-module resets
    req_allowed = 1;
    exp_addr = 7'h7f;
    dmi_scan(7'h7f, 32'h0, 2'd1, dout);
    await_response();
    req_allowed = 0;
    dmi_scan(7'h00, 32'h0, 2'd0, dout);
    check_value("dmi op after error", dout[1:0], 64'h2);
    load_ir(5'h10);
    cnt = rst_count;
    scan(1'b0, 32, 64'h0002_0000, dout);
    check_value("dtmcs dmistat error", dout[11:10], 64'h2);
    repeat (2) @(posedge tck);
    check_value("hardreset pulse count", 64'(rst_count), 64'(cnt + 1));
    cnt = rst_count;
    enter_tlr();
    repeat (2) @(posedge tck);
    assert (rst_count > cnt)
      else stop_on_error("dmi_rst_no did not pulse in Test-Logic-Reset");
    scan(1'b0, 32, 64'h0, dout);
    check_value("idcode after tlr", dout[31:0], 64'(`DTM_IDCODE));
    $display("all tests passed");
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock and reset source
 * 4 ns tck, trst held low for 2 cycles
 */

`timescale 1ns/1ns

module tb_clk_gen (
  output logic tck_o,
  output logic trst_no
);

  initial begin
    tck_o   = 1'b0;
    trst_no = 1'b0;
    repeat (2) @(posedge tck_o);
    trst_no <= 1'b1;
  end

  always #2 tck_o = ~tck_o;

endmodule

/* src/dtm_cfg.svh */
/*
 * Build-time configuration of the JTAG DTM
 * IR length, IDCODE value, DMI address width, DTMCS version
 */

`ifndef DTM_CFG_SVH
`define DTM_CFG_SVH

// Instruction register width in bits
`define DTM_IR_LEN 5

// IDCODE word, bit 0 must stay set as the standard requires
`define DTM_IDCODE 32'h1beef001

// Address bits of a DMI access, reported as abits in DTMCS
`define DTM_ABITS 7

// DTMCS version field, 1 means debug spec 0.13
`define DTM_VERSION 1

`endif

/* src/dtm_dmi_port.sv */
/*
 * DMI side of the DTM
 * Request issue, response capture, busy and sticky status
 * DTMCS capture value, dmireset and debug-module reset pulse
 */

`timescale 1ns/1ns

`include "dtm_cfg.svh"

module dtm_dmi_port (
  input  logic                  tck_i,
  input  logic                  trst_ni,
  input  logic                  dmi_clear_i,
  // DTMCS register
  input  logic                  dtmcs_update_i,
  input  dtm_pkg::dtmcs_t       dtmcs_val_i,
  output dtm_pkg::dtmcs_t       dtmcs_capture_o,
  // DMI access register
  input  logic                  dmi_update_i,
  input  dtm_pkg::dmi_t         dmi_val_i,
  input  logic                  dmi_capture_i,
  input  logic                  dmi_select_i,
  output dtm_pkg::dmi_t         dmi_capture_o,
  // Debug module strobes
  output logic                  dmi_req_valid_o,
  output logic [`DTM_ABITS-1:0] dmi_req_addr_o,
  output dtm_pkg::dmi_op_e      dmi_req_op_o,
  output logic [31:0]           dmi_req_data_o,
  output logic                  dmi_rst_no,
  input  logic                  dmi_resp_valid_i,
  input  logic [31:0]           dmi_resp_data_i,
  input  logic                  dmi_resp_err_i
);

  logic             pending_q;
  logic [31:0]      resp_data_q;
  dtm_pkg::dmi_op_e sticky_q;
  logic             issue, busy_capture, clear_sticky, hard_reset;

  // Only reads and writes reach the debug module
  assign issue = dmi_update_i && !pending_q && (sticky_q == dtm_pkg::DMI_SUCCESS)
                 && (dmi_val_i.op == dtm_pkg::DMI_READ || dmi_val_i.op == dtm_pkg::DMI_WRITE);
  // Scan landed on an unanswered request
  assign busy_capture = dmi_capture_i && dmi_select_i && pending_q
                        && (sticky_q == dtm_pkg::DMI_SUCCESS);
  assign hard_reset   = dtmcs_update_i && dtmcs_val_i.dmihardreset;
  assign clear_sticky = dmi_clear_i || hard_reset || (dtmcs_update_i && dtmcs_val_i.dmireset);

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      pending_q       <= 1'b0;
      dmi_req_valid_o <= 1'b0;
      resp_data_q     <= '0;
      sticky_q        <= dtm_pkg::DMI_SUCCESS;
      dmi_rst_no      <= 1'b1;
    end else begin
      dmi_req_valid_o <= issue;
      if (issue) begin
        pending_q <= 1'b1;
      end else if (dmi_resp_valid_i) begin
        pending_q <= 1'b0;
      end
      if (dmi_resp_valid_i) begin
        resp_data_q <= dmi_resp_data_i;
      end
      // Later lines take priority, a reset beats a new fault
      if (busy_capture) begin
        sticky_q <= dtm_pkg::DMI_BUSY;
      end
      if (dmi_resp_valid_i && dmi_resp_err_i) begin
        sticky_q <= dtm_pkg::DMI_ERROR;
      end
      if (clear_sticky) begin
        sticky_q <= dtm_pkg::DMI_SUCCESS;
      end
      // Low for one cycle per hardreset write, held in TLR
      dmi_rst_no <= !(dmi_clear_i || hard_reset);
    end
  end

  // Request fields hold until the next issue
  always_ff @(posedge tck_i) begin
    if (issue) begin
      dmi_req_addr_o <= dmi_val_i.address;
      dmi_req_op_o   <= dmi_val_i.op;
      dmi_req_data_o <= dmi_val_i.data;
    end
  end

  // --------------------
  // Capture values
  // --------------------
  always_comb begin
    dmi_capture_o.address = dmi_req_addr_o;
    dmi_capture_o.data    = resp_data_q;
    // Sticky first, then live busy
    if (sticky_q != dtm_pkg::DMI_SUCCESS) begin
      dmi_capture_o.op = sticky_q;
    end else if (pending_q) begin
      dmi_capture_o.op = dtm_pkg::DMI_BUSY;
    end else begin
      dmi_capture_o.op = dtm_pkg::DMI_SUCCESS;
    end
  end

  always_comb begin
    dtmcs_capture_o         = '0;
    dtmcs_capture_o.idle    = 3'd1;
    dtmcs_capture_o.dmistat = sticky_q;
    dtmcs_capture_o.abits   = 6'(`DTM_ABITS);
    dtmcs_capture_o.version = 4'(`DTM_VERSION);
  end

  // Debug module answers only what was asked
  a_resp_pending: assert property (@(posedge tck_i) disable iff (!trst_ni)
    dmi_resp_valid_i |-> pending_q);

  // A strobe never overlaps an outstanding request
  a_no_overlap: assert property (@(posedge tck_i) disable iff (!trst_ni)
    dmi_req_valid_o |-> !$past(pending_q));

endmodule

/* src/dtm_dr_shift.sv */
/*
 * Generic JTAG data register
 * Capture, LSB-first shift and update of one payload type
 */

`timescale 1ns/1ns

module dtm_dr_shift #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     tck_i,
  input  logic     trst_ni,
  input  logic     capture_i,
  input  logic     shift_i,
  input  logic     update_i,
  input  logic     select_i,
  input  logic     tdi_i,
  input  payload_t capture_val_i,
  output logic     tdo_o,
  output logic     update_o,
  output payload_t update_val_o
);

  localparam int unsigned Width = $bits(payload_t);

  // Scan chain segment
  logic [Width-1:0] shift_q;

  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      shift_q <= '0;
    end else if (select_i) begin
      // Parallel load in Capture-DR
      if (capture_i) begin
        shift_q <= capture_val_i;
      // tdi enters at the top, LSB leaves first
      end else if (shift_i) begin
        shift_q <= {tdi_i, shift_q[Width-1:1]};
      end
    end
  end

  assign tdo_o = shift_q[0];

  // --------------------
  // Update
  // --------------------
  // Contents are frozen in Update-DR, so the strobe and the value
  // are valid together for that single cycle
  assign update_o     = update_i & select_i;
  assign update_val_o = payload_t'(shift_q);

  // TAP decodes are mutually exclusive states
  a_dr_strobes: assert property (@(posedge tck_i) disable iff (!trst_ni)
    $onehot0({capture_i, shift_i, update_i}));

endmodule

/* src/dtm_pkg.sv */
/*
 * Shared DTM types
 * Instruction codes, DMI op codes, DMI and DTMCS payloads
 */

`include "dtm_cfg.svh"

package dtm_pkg;

  // JTAG instructions, any other code falls back to bypass
  typedef enum logic [`DTM_IR_LEN-1:0] {
    BYPASS0   = 'h00,
    IDCODE    = 'h01,
    DTMCS     = 'h10,
    DMIACCESS = 'h11,
    BYPASS1   = 'h1f
  } ir_e;

  // Request codes as sent, status codes as captured
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2,
    DMI_BUSY  = 2'd3
  } dmi_op_e;

  // Status names sharing the request encodings
  localparam dmi_op_e DMI_SUCCESS = DMI_NOP;
  localparam dmi_op_e DMI_ERROR   = DMI_WRITE;

  // DMI scan word, op sits in the lowest bits
  typedef struct packed {
    logic [`DTM_ABITS-1:0] address;
    logic [31:0]           data;
    dmi_op_e               op;
  } dmi_t;

  // DTMCS layout as per debug spec 0.13
  typedef struct packed {
    logic [13:0] zero1;
    logic        dmihardreset;
    logic        dmireset;
    logic        zero0;
    logic [2:0]  idle;
    dmi_op_e     dmistat;
    logic [5:0]  abits;
    logic [3:0]  version;
  } dtmcs_t;

endpackage

/* src/dtm_tap.sv */
/*
 * JTAG TAP controller for the DTM
 * 16-state FSM, instruction register, BYPASS and IDCODE
 * Data register selects and falling-edge TDO
 */

`timescale 1ns/1ns

`include "dtm_cfg.svh"

module dtm_tap (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  output logic td_o,
  output logic tdo_oe_o,
  // Strobes towards the custom data registers
  output logic tdi_o,
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic update_dr_o,
  output logic dtmcs_select_o,
  output logic dmi_select_o,
  output logic dmi_clear_o,
  // Serial outputs of the custom data registers
  input  logic dtmcs_tdo_i,
  input  logic dmi_tdo_i
);

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET, RUN_TEST_IDLE, SELECT_DR_SCAN,
    CAPTURE_DR, SHIFT_DR, EXIT1_DR, PAUSE_DR, EXIT2_DR,
    UPDATE_DR, SELECT_IR_SCAN, CAPTURE_IR, SHIFT_IR,
    EXIT1_IR, PAUSE_IR, EXIT2_IR, UPDATE_IR
  } tap_state_e;

  tap_state_e tap_state_q, tap_state_d;

  // State decodes
  logic test_logic_reset;
  logic capture_ir, shift_ir, update_ir;
  logic capture_dr, shift_dr, update_dr;

  // --------------------
  // TAP FSM
  // --------------------
  // Next state follows tms_i on every rising edge
  always_comb begin
    case (tap_state_q)
      TEST_LOGIC_RESET: tap_state_d = tms_i ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    tap_state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      // DR column
      SELECT_DR_SCAN:   tap_state_d = tms_i ? SELECT_IR_SCAN   : CAPTURE_DR;
      CAPTURE_DR:       tap_state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
      SHIFT_DR:         tap_state_d = tms_i ? EXIT1_DR         : SHIFT_DR;
      EXIT1_DR:         tap_state_d = tms_i ? UPDATE_DR        : PAUSE_DR;
      PAUSE_DR:         tap_state_d = tms_i ? EXIT2_DR         : PAUSE_DR;
      EXIT2_DR:         tap_state_d = tms_i ? UPDATE_DR        : SHIFT_DR;
      UPDATE_DR:        tap_state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      // IR column
      SELECT_IR_SCAN:   tap_state_d = tms_i ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       tap_state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
      SHIFT_IR:         tap_state_d = tms_i ? EXIT1_IR         : SHIFT_IR;
      EXIT1_IR:         tap_state_d = tms_i ? UPDATE_IR        : PAUSE_IR;
      PAUSE_IR:         tap_state_d = tms_i ? EXIT2_IR         : PAUSE_IR;
      EXIT2_IR:         tap_state_d = tms_i ? UPDATE_IR        : SHIFT_IR;
      UPDATE_IR:        tap_state_d = tms_i ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      default:          tap_state_d = TEST_LOGIC_RESET;
    endcase
  end

  // Reset parks the controller in Run-Test-Idle
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      tap_state_q <= RUN_TEST_IDLE;
    end else begin
      tap_state_q <= tap_state_d;
    end
  end

  assign test_logic_reset = (tap_state_q == TEST_LOGIC_RESET);
  assign capture_ir       = (tap_state_q == CAPTURE_IR);
  assign shift_ir         = (tap_state_q == SHIFT_IR);
  assign update_ir        = (tap_state_q == UPDATE_IR);
  assign capture_dr       = (tap_state_q == CAPTURE_DR);
  assign shift_dr         = (tap_state_q == SHIFT_DR);
  assign update_dr        = (tap_state_q == UPDATE_DR);

  // --------------------
  // Instruction register
  // --------------------
  logic [`DTM_IR_LEN-1:0] ir_shift_q;
  dtm_pkg::ir_e           ir_q;

  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      ir_shift_q <= '0;
      ir_q       <= dtm_pkg::IDCODE;
    end else begin
      // Capture pattern ends in 01 as the standard demands
      if (capture_ir) begin
        ir_shift_q <= `DTM_IR_LEN'(2'b01);
      end else if (shift_ir) begin
        ir_shift_q <= {td_i, ir_shift_q[`DTM_IR_LEN-1:1]};
      end
      // TLR restores IDCODE, Update-IR takes the shifted code
      if (test_logic_reset) begin
        ir_q <= dtm_pkg::IDCODE;
      end else if (update_ir) begin
        ir_q <= dtm_pkg::ir_e'(ir_shift_q);
      end
    end
  end

  // --------------------
  // Built-in DRs
  // --------------------
  logic        idcode_select, bypass_select;
  logic [31:0] idcode_q;
  logic        bypass_q;

  // Decode the current instruction into one select
  always_comb begin
    idcode_select  = 1'b0;
    bypass_select  = 1'b0;
    dtmcs_select_o = 1'b0;
    dmi_select_o   = 1'b0;
    case (ir_q)
      dtm_pkg::IDCODE:    idcode_select  = 1'b1;
      dtm_pkg::DTMCS:     dtmcs_select_o = 1'b1;
      dtm_pkg::DMIACCESS: dmi_select_o   = 1'b1;
      default:            bypass_select  = 1'b1;
    endcase
  end

  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      idcode_q <= `DTM_IDCODE;
      bypass_q <= 1'b0;
    end else begin
      if (capture_dr && idcode_select) begin
        idcode_q <= `DTM_IDCODE;
      end else if (shift_dr && idcode_select) begin
        idcode_q <= {td_i, idcode_q[31:1]};
      end
      // Bypass captures 0 so the first bit out is known
      if (capture_dr && bypass_select) begin
        bypass_q <= 1'b0;
      end else if (shift_dr && bypass_select) begin
        bypass_q <= td_i;
      end
    end
  end

  // --------------------
  // TDO path
  // --------------------
  logic tdo_mux;

  always_comb begin
    if (shift_ir) begin
      tdo_mux = ir_shift_q[0];
    end else if (idcode_select) begin
      tdo_mux = idcode_q[0];
    end else if (dtmcs_select_o) begin
      tdo_mux = dtmcs_tdo_i;
    end else if (dmi_select_o) begin
      tdo_mux = dmi_tdo_i;
    end else begin
      tdo_mux = bypass_q;
    end
  end

  // Pad output moves half a cycle after the state
  always_ff @(negedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      td_o     <= 1'b0;
      tdo_oe_o <= 1'b0;
    end else begin
      td_o     <= tdo_mux;
      tdo_oe_o <= shift_ir | shift_dr;
    end
  end

  // Strobes for the custom DRs
  assign tdi_o        = td_i;
  assign capture_dr_o = capture_dr;
  assign shift_dr_o   = shift_dr;
  assign update_dr_o  = update_dr;
  assign dmi_clear_o  = test_logic_reset;

  // Enable set on the falling edge must match the state seen on the rising one
  a_oe_only_shift: assert property (@(posedge tck_i) disable iff (!trst_ni)
    tdo_oe_o |-> (shift_ir || shift_dr));

  // One data register on the chain at a time
  a_one_select: assert property (@(posedge tck_i) disable iff (!trst_ni)
    $onehot0({idcode_select, bypass_select, dtmcs_select_o, dmi_select_o}));

endmodule

/* src/dtm_top.sv */
/*
 * JTAG DTM top level
 * TAP, DTMCS and DMI data registers, DMI port
 */

`timescale 1ns/1ns

`include "dtm_cfg.svh"

module dtm_top (
  input  logic                  tck_i,
  input  logic                  trst_ni,
  input  logic                  tms_i,
  input  logic                  td_i,
  output logic                  td_o,
  output logic                  tdo_oe_o,
  // Debug module interface
  output logic                  dmi_req_valid_o,
  output logic [`DTM_ABITS-1:0] dmi_req_addr_o,
  output dtm_pkg::dmi_op_e      dmi_req_op_o,
  output logic [31:0]           dmi_req_data_o,
  output logic                  dmi_rst_no,
  input  logic                  dmi_resp_valid_i,
  input  logic [31:0]           dmi_resp_data_i,
  input  logic                  dmi_resp_err_i
);

  // TAP strobes
  logic tdi, capture_dr, shift_dr, update_dr, dmi_clear;
  logic dtmcs_select, dmi_select, dtmcs_tdo, dmi_tdo;

  // DR payloads
  logic            dtmcs_update, dmi_update;
  dtm_pkg::dtmcs_t dtmcs_capture, dtmcs_val;
  dtm_pkg::dmi_t   dmi_capture, dmi_val;

  dtm_tap tap_i (
    .tck_i          (tck_i),
    .trst_ni        (trst_ni),
    .tms_i          (tms_i),
    .td_i           (td_i),
    .td_o           (td_o),
    .tdo_oe_o       (tdo_oe_o),
    .tdi_o          (tdi),
    .capture_dr_o   (capture_dr),
    .shift_dr_o     (shift_dr),
    .update_dr_o    (update_dr),
    .dtmcs_select_o (dtmcs_select),
    .dmi_select_o   (dmi_select),
    .dmi_clear_o    (dmi_clear),
    .dtmcs_tdo_i    (dtmcs_tdo),
    .dmi_tdo_i      (dmi_tdo)
  );

  dtm_dr_shift #(.payload_t(dtm_pkg::dtmcs_t)) dtmcs_dr (
    .tck_i         (tck_i),
    .trst_ni       (trst_ni),
    .capture_i     (capture_dr),
    .shift_i       (shift_dr),
    .update_i      (update_dr),
    .select_i      (dtmcs_select),
    .tdi_i         (tdi),
    .capture_val_i (dtmcs_capture),
    .tdo_o         (dtmcs_tdo),
    .update_o      (dtmcs_update),
    .update_val_o  (dtmcs_val)
  );

  dtm_dr_shift #(.payload_t(dtm_pkg::dmi_t)) dmi_dr (
    .tck_i         (tck_i),
    .trst_ni       (trst_ni),
    .capture_i     (capture_dr),
    .shift_i       (shift_dr),
    .update_i      (update_dr),
    .select_i      (dmi_select),
    .tdi_i         (tdi),
    .capture_val_i (dmi_capture),
    .tdo_o         (dmi_tdo),
    .update_o      (dmi_update),
    .update_val_o  (dmi_val)
  );

  dtm_dmi_port dmi_port_i (
    .tck_i            (tck_i),
    .trst_ni          (trst_ni),
    .dmi_clear_i      (dmi_clear),
    .dtmcs_update_i   (dtmcs_update),
    .dtmcs_val_i      (dtmcs_val),
    .dtmcs_capture_o  (dtmcs_capture),
    .dmi_update_i     (dmi_update),
    .dmi_val_i        (dmi_val),
    .dmi_capture_i    (capture_dr),
    .dmi_select_i     (dmi_select),
    .dmi_capture_o    (dmi_capture),
    .dmi_req_valid_o  (dmi_req_valid_o),
    .dmi_req_addr_o   (dmi_req_addr_o),
    .dmi_req_op_o     (dmi_req_op_o),
    .dmi_req_data_o   (dmi_req_data_o),
    .dmi_rst_no       (dmi_rst_no),
    .dmi_resp_valid_i (dmi_resp_valid_i),
    .dmi_resp_data_i  (dmi_resp_data_i),
    .dmi_resp_err_i   (dmi_resp_err_i)
  );

endmodule
